//--- cycle_timer.sv
// KC and PC one-shots as counted clock ticks, spacing the sequencer's state transitions
`timescale 1ns/1ps
`default_nettype none
`include "pm_config.svh"

module cycle_timer(
	input logic __clk,
	input logic reset,
	input logic kc_req,
	output logic kc,
	output logic pc,
	output logic cycle_done
);

	localparam int MAX_TICKS = (`PM_KC_TICKS > `PM_PC_TICKS) ? `PM_KC_TICKS : `PM_PC_TICKS;
	localparam int CNT_W = $clog2(MAX_TICKS + 1);
	localparam logic [CNT_W-1:0] KC_LOAD = CNT_W'(`PM_KC_TICKS - 1);
	localparam logic [CNT_W-1:0] PC_LOAD = CNT_W'(`PM_PC_TICKS - 1);

	localparam logic [1:0] PH_IDLE = 2'd0;
	localparam logic [1:0] PH_KC = 2'd1;
	localparam logic [1:0] PH_PC = 2'd2;

	logic [1:0] phase;
	logic [CNT_W-1:0] ticks;

	always_ff @(posedge __clk) begin
		if (reset) begin
			phase <= PH_IDLE;
			ticks <= '0;
			cycle_done <= 1'b0;
		end else begin
			cycle_done <= 1'b0;
			case (phase)
				PH_IDLE: if (kc_req) begin
					phase <= PH_KC;
					ticks <= KC_LOAD;
				end
				// KC runs out, PC fires off its trailing edge
				PH_KC: if (ticks == '0) begin
					phase <= PH_PC;
					ticks <= PC_LOAD;
				end else begin
					ticks <= ticks - 1'b1;
				end
				PH_PC: if (ticks == '0) begin
					phase <= PH_IDLE;
					cycle_done <= 1'b1;
				end else begin
					ticks <= ticks - 1'b1;
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	assign kc = (phase == PH_KC);
	assign pc = (phase == PH_PC);

	a_req_idle: assert property (
		@(posedge __clk) disable iff (reset) kc_req |-> phase == PH_IDLE
	) else $error("kc_req while timer busy, request dropped");

	a_kc_pc_excl: assert property (
		@(posedge __clk) disable iff (reset) !(kc && pc)
	) else $error("kc and pc high together");

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
pm_pkg.sv
run_ctl.sv
cycle_timer.sv
state_seq.sv
loop_cnt.sv
uop_decode.sv
pm_top.sv
pm_checker.sv
tb_pm.sv

//--- loop_cnt.sv
// LG group counter and LK step counter, preloaded on entry to P5 and stepped per microoperation
`timescale 1ns/1ps
`default_nettype none

module loop_cnt(
	input logic __clk,
	input logic reset,
	input logic preload,
	input logic step,
	input pm_pkg::instr_word_t ir,
	output logic [2:0] lg,
	output logic lg_done,
	output logic lk_zero
);

	import pm_pkg::*;

	logic [3:0] lk;

	// LG counts up from field a
	always_ff @(posedge __clk) begin
		if (reset) begin
			lg <= 3'd0;
		end else if (preload) begin
			lg <= ir.n.a;
		end else if (step) begin
			lg <= lg + 3'd1;
		end
	end

	// LK counts down from the short count
	always_ff @(posedge __clk) begin
		if (reset) begin
			lk <= 4'd0;
		end else if (preload) begin
			lk <= ir.s.count;
		end else if (step) begin
			lk <= lk - 4'd1;
		end
	end

	assign lg_done = (lg == 3'd7);
	assign lk_zero = (lk == 4'd0);

	// decoder must stop stepping once both loops are exhausted
	a_no_overstep: assert property (
		@(posedge __clk) disable iff (reset) step |-> !(lg_done && lk_zero)
	) else $error("step with LG at 7 and LK at zero");

	a_preload_alone: assert property (
		@(posedge __clk) disable iff (reset) preload |-> !step
	) else $error("step in the preload cycle");

endmodule

`default_nettype wire

//--- pm_checker.sv
// testbench checker, records control unit events in order and compares them with the predicted list
`timescale 1ns/1ps
`default_nettype none

module pm_checker(
	input logic __clk,
	input logic reset,
	input pm_pkg::cycle_state_t state,
	input logic enter,
	input logic run,
	input logic wait_ind,
	input logic mem_req,
	input logic irq_ack,
	input logic w_ir,
	input logic w_ar,
	input logic w_r,
	input logic w_ac,
	input logic [2:0] reg_sel,
	output int mismatches,
	output int extras,
	output int missing
);

	import pm_pkg::*;

	// event code is kind in [15:12], data below
	localparam logic [3:0] EV_ENTER = 4'd1;
	localparam logic [3:0] EV_WIR = 4'd2;
	localparam logic [3:0] EV_WAR = 4'd3;
	localparam logic [3:0] EV_WR = 4'd4;
	localparam logic [3:0] EV_WAC = 4'd5;
	localparam logic [3:0] EV_IACK = 4'd6;

	logic [15:0] expected [$];
	int seen;

	initial begin
		mismatches = 0;
		extras = 0;
		missing = 0;
		seen = 0;
	end

	function automatic string describe(input logic [15:0] code);
		case (code[15:12])
			EV_ENTER: return $sformatf("enter P%0d (run %0b, wait %0b)", code[2:0], code[4], code[3]);
			EV_WIR: return "w_ir";
			EV_WAR: return "w_ar";
			EV_WR: return $sformatf("w_r reg %0d", code[2:0]);
			EV_WAC: return "w_ac";
			EV_IACK: return "irq_ack";
			default: return $sformatf("unknown code %h", code);
		endcase
	endfunction

	task automatic compare_event(input logic [15:0] code);
		logic [15:0] want;
		seen++;
		if (expected.size() == 0) begin
			extras++;
			$display("unexpected event %0d at %0t: %s", seen, $time, describe(code));
		end else begin
			want = expected.pop_front();
			if (want != code) begin
				mismatches++;
				$display("Mismatch at %0t: event %0d is %s, expected %s",
					$time, seen, describe(code), describe(want));
			end
		end
	endtask

	// whatever is left over never happened
	task automatic close_check();
		missing = expected.size();
		while (expected.size() > 0)
			$display("expected event never seen: %s", describe(expected.pop_front()));
	endtask

	// irq_ack shares a cycle with the enter of P1 and is taken first
	always @(posedge __clk) begin
		if (!reset) begin
			if (irq_ack)
				compare_event({EV_IACK, 12'd0});
			if (enter)
				compare_event({EV_ENTER, 7'd0,
					(state == ST_P0) ? {run, wait_ind} : 2'b00, state});
			if (w_ir)
				compare_event({EV_WIR, 12'd0});
			if (w_ar)
				compare_event({EV_WAR, 12'd0});
			if (w_r)
				compare_event({EV_WR, 9'd0, reg_sel});
			if (w_ac)
				compare_event({EV_WAC, 12'd0});
			// memory is only read in the fetch and argument states
			if (mem_req && state != ST_P1 && state != ST_P4) begin
				mismatches++;
				$display("Mismatch at %0t: mem_req high in P%0d", $time, state);
			end
		end
	end

endmodule

`default_nettype wire

//--- pm_config.svh
// timing and width constants for the microinstruction control unit, included by the RTL and testbench
`ifndef PM_CONFIG_SVH
`define PM_CONFIG_SVH

// cycle end one-shot (KC) length in clocks
`define PM_KC_TICKS 3

// cycle start one-shot (PC) length in clocks
`define PM_PC_TICKS 2

// instruction word as read from memory
`define PM_WORD 16

`endif

//--- pm_pkg.sv
// shared types and opcode constants of the control unit, imported by RTL and testbench
`default_nettype none

package pm_pkg;

	// main loop states
	typedef enum logic [2:0] {
		ST_P0 = 3'd0,
		ST_P1 = 3'd1,
		ST_P2 = 3'd2,
		ST_P3 = 3'd3,
		ST_P4 = 3'd4,
		ST_P5 = 3'd5
	} cycle_state_t;

	// two-register format
	typedef struct packed {
		logic [5:0] opcode;
		logic       d;
		logic [2:0] a;
		logic [2:0] b;
		logic [2:0] c;
	} instr_norm_t;

	// short-argument format, used by shifts
	typedef struct packed {
		logic [5:0] opcode;
		logic       d;
		logic [4:0] ext;
		logic [3:0] count;
	} instr_short_t;

	// one word, decoded in both ways depending on the opcode
	typedef union packed {
		instr_norm_t  n;
		instr_short_t s;
	} instr_word_t;

	// register load, argument fetched in P4
	localparam logic [5:0] OP_LW  = 6'o20;
	// register group load, argument fetched in P4
	localparam logic [5:0] OP_LWS = 6'o21;
	// shift by short count
	localparam logic [5:0] OP_SHC = 6'o36;
	// halt, sets WAIT
	localparam logic [5:0] OP_HLT = 6'o56;

endpackage

`default_nettype wire

//--- pm_top.sv
// top level of the microinstruction control unit, wiring run control, timer, sequencer, counters and decoder
`timescale 1ns/1ps
`default_nettype none
`include "pm_config.svh"

module pm_top(
	input logic __clk,
	input logic reset,
	input logic start_req,
	input logic stop_req,
	input logic clear_req,
	input logic irq,
	input logic mem_ok,
	input logic [`PM_WORD-1:0] rdata,
	output logic run,
	output logic wait_ind,
	output pm_pkg::cycle_state_t state,
	output logic enter,
	output logic mem_req,
	output logic irq_ack,
	output logic w_ir,
	output logic w_ar,
	output logic w_r,
	output logic w_ac,
	output logic [2:0] reg_sel
);

	import pm_pkg::*;

	instr_word_t ir;
	logic halt;
	logic kc_req;
	logic kc;
	logic pc;
	logic cycle_done;
	logic preload;
	logic exec_done;
	logic step;
	logic [2:0] lg;
	logic lg_done;
	logic lk_zero;

	run_ctl run_ctl_inst(
		.__clk(__clk),
		.reset(reset),
		.start_req(start_req),
		.stop_req(stop_req),
		.clear_req(clear_req),
		.halt(halt),
		.run(run),
		.wait_ind(wait_ind)
	);

	cycle_timer cycle_timer_inst(
		.__clk(__clk),
		.reset(reset),
		.kc_req(kc_req),
		.kc(kc),
		.pc(pc),
		.cycle_done(cycle_done)
	);

	state_seq state_seq_inst(
		.__clk(__clk),
		.reset(reset),
		.run(run),
		.irq(irq),
		.mem_ok(mem_ok),
		.rdata(rdata),
		.cycle_done(cycle_done),
		.exec_done(exec_done),
		.state(state),
		.enter(enter),
		.kc_req(kc_req),
		.preload(preload),
		.mem_req(mem_req),
		.irq_ack(irq_ack),
		.ir(ir)
	);

	loop_cnt loop_cnt_inst(
		.__clk(__clk),
		.reset(reset),
		.preload(preload),
		.step(step),
		.ir(ir),
		.lg(lg),
		.lg_done(lg_done),
		.lk_zero(lk_zero)
	);

	uop_decode uop_decode_inst(
		.__clk(__clk),
		.reset(reset),
		.state(state),
		.enter(enter),
		.mem_ok(mem_ok),
		.ir(ir),
		.lg(lg),
		.lg_done(lg_done),
		.lk_zero(lk_zero),
		.w_ir(w_ir),
		.w_ar(w_ar),
		.w_r(w_r),
		.w_ac(w_ac),
		.reg_sel(reg_sel),
		.step(step),
		.halt(halt),
		.exec_done(exec_done)
	);

endmodule

`default_nettype wire

//--- run_ctl.sv
// run control with START and WAIT flip-flops, set and cleared by panel pulses and HLT
`timescale 1ns/1ps
`default_nettype none

module run_ctl(
	input logic __clk,
	input logic reset,
	input logic start_req,
	input logic stop_req,
	input logic clear_req,
	input logic halt,
	output logic run,
	output logic wait_ind
);

	logic start_ff;
	logic wait_ff;

	// START: cleared by stop or clear, set by start
	always_ff @(posedge __clk) begin
		if (reset) begin
			start_ff <= 1'b0;
		end else if (stop_req || clear_req) begin
			start_ff <= 1'b0;
		end else if (start_req) begin
			start_ff <= 1'b1;
		end
	end

	// WAIT: set by HLT, released by start or clear
	always_ff @(posedge __clk) begin
		if (reset) begin
			wait_ff <= 1'b0;
		end else if (start_req || clear_req) begin
			wait_ff <= 1'b0;
		end else if (halt) begin
			wait_ff <= 1'b1;
		end
	end

	assign run = start_ff & ~wait_ff;
	assign wait_ind = wait_ff;

	// a halt from the decoder stops the machine on the next clock
	a_halt_stops: assert property (
		@(posedge __clk) disable iff (reset)
		halt && !start_req && !clear_req |=> wait_ind && !run
	) else $error("run still high after halt");

endmodule

`default_nettype wire

//--- state_seq.sv
// main loop sequencer P0..P5 with instruction register and PR, PP, WP, WB flags
`timescale 1ns/1ps
`default_nettype none
`include "pm_config.svh"

module state_seq(
	input logic __clk,
	input logic reset,
	input logic run,
	input logic irq,
	input logic mem_ok,
	input logic [`PM_WORD-1:0] rdata,
	input logic cycle_done,
	input logic exec_done,
	output pm_pkg::cycle_state_t state,
	output logic enter,
	output logic kc_req,
	output logic preload,
	output logic mem_req,
	output logic irq_ack,
	output pm_pkg::instr_word_t ir
);

	import pm_pkg::*;

	instr_word_t fetched;
	cycle_state_t nxt;
	logic kc_sent;
	logic pr;
	logic pp;
	logic wp;
	logic wb;
	logic need_arg;
	logic fetch_done;
	logic work_done;

	// path through P2..P4 once the earlier steps are done
	function automatic cycle_state_t path_from(input logic d_pend, input logic b_pend,
			input logic arg);
		if (d_pend)
			return ST_P2;
		if (b_pend)
			return ST_P3;
		if (arg)
			return ST_P4;
		return ST_P5;
	endfunction

	assign fetched = rdata;
	assign need_arg = (ir.n.opcode == OP_LW) || (ir.n.opcode == OP_LWS);
	assign fetch_done = (state == ST_P1) && pr && mem_ok;

	always_comb begin
		case (state)
			ST_P0: nxt = ST_P1;
			ST_P1: nxt = path_from(wp, wb, need_arg);
			ST_P2: nxt = path_from(1'b0, wb, need_arg);
			ST_P3: nxt = path_from(1'b0, 1'b0, need_arg);
			ST_P4: nxt = ST_P5;
			ST_P5: nxt = (pp || run) ? ST_P1 : ST_P0;
			default: nxt = ST_P0;
		endcase
	end

	// end of the work in the current state, one per state
	always_comb begin
		case (state)
			ST_P0: work_done = run;
			ST_P1: work_done = fetch_done;
			ST_P2, ST_P3: work_done = 1'b1;
			ST_P4: work_done = mem_ok;
			ST_P5: work_done = exec_done;
			default: work_done = 1'b0;
		endcase
		work_done = work_done && !kc_sent;
	end

	assign mem_req = ((state == ST_P1) && pr) || ((state == ST_P4) && !kc_sent);

	always_ff @(posedge __clk) begin
		if (reset) begin
			state <= ST_P0;
			enter <= 1'b0;
			kc_req <= 1'b0;
			kc_sent <= 1'b0;
			preload <= 1'b0;
			irq_ack <= 1'b0;
			pr <= 1'b0;
			pp <= 1'b0;
			wp <= 1'b0;
			wb <= 1'b0;
		end else begin
			kc_req <= work_done;
			enter <= cycle_done;
			preload <= cycle_done && (nxt == ST_P5);
			irq_ack <= cycle_done && (state == ST_P5) && pp;
			if (cycle_done)
				state <= nxt;
			if (cycle_done)
				kc_sent <= 1'b0;
			else if (work_done)
				kc_sent <= 1'b1;
			// PR marks a pending instruction fetch
			if (cycle_done && nxt == ST_P1)
				pr <= 1'b1;
			else if (fetch_done)
				pr <= 1'b0;
			// interrupt taken at the end of P5, held through the next fetch
			if (work_done && state == ST_P5)
				pp <= irq;
			else if (fetch_done)
				pp <= 1'b0;
			if (fetch_done)
				wp <= fetched.n.d;
			else if (cycle_done && state == ST_P2)
				wp <= 1'b0;
			if (fetch_done)
				wb <= |fetched.n.b;
			else if (cycle_done && state == ST_P3)
				wb <= 1'b0;
		end
	end

	always_ff @(posedge __clk) begin
		if (fetch_done)
			ir <= fetched;
	end

	// a memory request holds until answered, in P1 or P4 only
	a_mem_req_hold: assert property (
		@(posedge __clk) disable iff (reset)
		mem_req && !mem_ok |=> mem_req && (state inside {ST_P1, ST_P4})
	) else $error("mem_req dropped or raised outside P1/P4");

endmodule

`default_nettype wire

//--- tb_pm.sv
// testbench top, runs an instruction list through the control unit and predicts every event
`timescale 1ns/1ps
`default_nettype none
`include "pm_config.svh"

module tb_pm;

	import pm_pkg::*;

	localparam logic [3:0] EV_ENTER = 4'd1;
	localparam logic [3:0] EV_WIR = 4'd2;
	localparam logic [3:0] EV_WAR = 4'd3;
	localparam logic [3:0] EV_WR = 4'd4;
	localparam logic [3:0] EV_WAC = 4'd5;
	localparam logic [3:0] EV_IACK = 4'd6;
	localparam int CYCLES_PER_INSTR = 64 + 2 * 6;

	logic __clk;
	logic reset;
	logic start_req;
	logic stop_req;
	logic clear_req;
	logic irq;
	logic mem_ok;
	logic [`PM_WORD-1:0] rdata;
	logic run;
	logic wait_ind;
	cycle_state_t state;
	logic enter;
	logic mem_req;
	logic irq_ack;
	logic w_ir;
	logic w_ar;
	logic w_r;
	logic w_ac;
	logic [2:0] reg_sel;
	int mismatches;
	int extras;
	int missing;

	logic [15:0] prog [$];
	bit irq_flag [$];
	bit stop_flag [$];
	int fetch_idx;
	int n_runs;
	bit list_ready;

	pm_top pm_top_inst(
		.__clk(__clk),
		.reset(reset),
		.start_req(start_req),
		.stop_req(stop_req),
		.clear_req(clear_req),
		.irq(irq),
		.mem_ok(mem_ok),
		.rdata(rdata),
		.run(run),
		.wait_ind(wait_ind),
		.state(state),
		.enter(enter),
		.mem_req(mem_req),
		.irq_ack(irq_ack),
		.w_ir(w_ir),
		.w_ar(w_ar),
		.w_r(w_r),
		.w_ac(w_ac),
		.reg_sel(reg_sel)
	);

	pm_checker pm_checker_inst(
		.__clk(__clk),
		.reset(reset),
		.state(state),
		.enter(enter),
		.run(run),
		.wait_ind(wait_ind),
		.mem_req(mem_req),
		.irq_ack(irq_ack),
		.w_ir(w_ir),
		.w_ar(w_ar),
		.w_r(w_r),
		.w_ac(w_ac),
		.reg_sel(reg_sel),
		.mismatches(mismatches),
		.extras(extras),
		.missing(missing)
	);

	initial begin
		__clk = 1'b0;
		forever #2 __clk = ~__clk;
	end

	function automatic logic [15:0] enter_code(input cycle_state_t st, input logic run_v,
			input logic wait_v);
		return {EV_ENTER, 7'd0, run_v, wait_v, st};
	endfunction

	// expected events of one instruction, from its P1 up to the next P1 or P0
	function automatic void predict_events(input instr_word_t w, input bit irq_on,
			input bit stop_on);
		logic [5:0] op;
		int r;
		op = w.n.opcode;
		pm_checker_inst.expected.push_back(enter_code(ST_P1, 1'b0, 1'b0));
		pm_checker_inst.expected.push_back({EV_WIR, 12'd0});
		if (w.n.d)
			pm_checker_inst.expected.push_back(enter_code(ST_P2, 1'b0, 1'b0));
		if (w.n.b != 3'd0)
			pm_checker_inst.expected.push_back(enter_code(ST_P3, 1'b0, 1'b0));
		if (op == OP_LW || op == OP_LWS) begin
			pm_checker_inst.expected.push_back(enter_code(ST_P4, 1'b0, 1'b0));
			pm_checker_inst.expected.push_back({EV_WAR, 12'd0});
		end
		pm_checker_inst.expected.push_back(enter_code(ST_P5, 1'b0, 1'b0));
		if (op == OP_LW)
			pm_checker_inst.expected.push_back({EV_WR, 9'd0, w.n.a});
		if (op == OP_LWS) begin
			for (r = w.n.a; r < 8; r++)
				pm_checker_inst.expected.push_back({EV_WR, 9'd0, r[2:0]});
		end
		if (op == OP_SHC) begin
			for (r = 0; r < w.s.count; r++)
				pm_checker_inst.expected.push_back({EV_WAC, 12'd0});
		end
		// a pending interrupt keeps the loop going even without run
		if (irq_on)
			pm_checker_inst.expected.push_back({EV_IACK, 12'd0});
		else if (op == OP_HLT || stop_on)
			pm_checker_inst.expected.push_back(enter_code(ST_P0, 1'b0, op == OP_HLT));
	endfunction

	task automatic add_instr(input logic [15:0] word, input bit irq_on, input bit stop_on);
		prog.push_back(word);
		irq_flag.push_back(irq_on);
		stop_flag.push_back(stop_on);
		predict_events(word, irq_on, stop_on);
		if (word[15:10] == OP_HLT || stop_on)
			n_runs++;
	endtask

	task automatic wait_for_p0();
		do begin
			@(posedge __clk);
			#1;
		end while (!(enter && state == ST_P0));
	endtask

	task automatic report_counts();
		$display("errors: %0d mismatched, %0d unexpected, %0d missing",
			mismatches, extras, missing);
	endtask

	initial begin : main
		int i;
		int r;
		int pick;
		bit irq_on;
		logic [31:0] draw;
		logic [15:0] word;
		reset = 1'b1;
		start_req = 1'b0;
		stop_req = 1'b0;
		clear_req = 1'b0;
		irq = 1'b0;
		mem_ok = 1'b0;
		rdata = '0;
		fetch_idx = 0;
		n_runs = 0;
		void'($urandom(32'hec02));
		// directed cases first
		add_instr({OP_LW, 1'b0, 3'd3, 3'd0, 3'd1}, 1'b0, 1'b0);
		add_instr({OP_LW, 1'b1, 3'd5, 3'd2, 3'd0}, 1'b0, 1'b0);
		add_instr({OP_LWS, 1'b0, 3'd2, 3'd0, 3'd4}, 1'b1, 1'b0);
		add_instr({OP_SHC, 1'b0, 5'd0, 4'd5}, 1'b0, 1'b0);
		add_instr({OP_SHC, 1'b1, 5'd0, 4'd0}, 1'b0, 1'b0);
		add_instr({6'o01, 1'b0, 3'd0, 3'd1, 3'd0}, 1'b0, 1'b0);
		add_instr({OP_HLT, 10'd0}, 1'b0, 1'b0);
		add_instr({OP_LWS, 1'b0, 3'd7, 3'd3, 3'd0}, 1'b0, 1'b0);
		add_instr({OP_SHC, 1'b0, 5'd3, 4'd3}, 1'b0, 1'b1);
		add_instr({OP_LW, 1'b0, 3'd0, 3'd0, 3'd7}, 1'b1, 1'b0);
		// random words, opcode forced to one of the kept classes or a NOP
		for (i = 0; i < 6; i++) begin
			draw = $urandom;
			word = draw[15:0];
			pick = $urandom % 4;
			irq_on = ($urandom % 4) == 0;
			case (pick)
				0: word[15:10] = OP_LW;
				1: word[15:10] = OP_LWS;
				2: word[15:10] = OP_SHC;
				default: word[15:10] = 6'o02;
			endcase
			add_instr(word, irq_on, 1'b0);
		end
		add_instr({OP_HLT, 10'd0}, 1'b0, 1'b0);
		list_ready = 1'b1;
		repeat (2) @(posedge __clk);
		#1;
		reset = 1'b0;
		// each run ends in P0, after HLT or a stop
		for (r = 0; r < n_runs; r++) begin
			@(posedge __clk);
			#1;
			start_req = 1'b1;
			@(posedge __clk);
			#1;
			start_req = 1'b0;
			wait_for_p0();
		end
		repeat (8) @(posedge __clk);
		pm_checker_inst.close_check();
		#1;
		report_counts();
		if (mismatches + extras + missing == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// memory stand-in, answers each request after 1 to 6 cycles
	initial begin : responder
		int delay;
		bit fetch;
		logic [31:0] draw;
		forever begin
			@(posedge __clk);
			#1;
			if (!reset && mem_req) begin
				fetch = (state == ST_P1);
				delay = 1 + ($urandom % 6);
				repeat (delay) @(posedge __clk);
				#1;
				if (fetch) begin
					if (fetch_idx < prog.size()) begin
						rdata = prog[fetch_idx];
						irq = irq_flag[fetch_idx];
						stop_req = stop_flag[fetch_idx];
					end else begin
						rdata = '0;
					end
					fetch_idx++;
				end else begin
					// argument word, the unit does not use it
					draw = $urandom;
					rdata = draw[15:0];
				end
				mem_ok = 1'b1;
				@(posedge __clk);
				#1;
				mem_ok = 1'b0;
				stop_req = 1'b0;
			end
		end
	end

	initial begin : watchdog
		int budget;
		wait (list_ready);
		budget = prog.size() * CYCLES_PER_INSTR;
		repeat (budget) @(posedge __clk);
		$display("timeout: run did not finish within %0d cycles", budget);
		pm_checker_inst.close_check();
		#1;
		report_counts();
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- uop_decode.sv
// microoperation decoder turning state, instruction and loop counters into write strobes
`timescale 1ns/1ps
`default_nettype none

module uop_decode(
	input logic __clk,
	input logic reset,
	input pm_pkg::cycle_state_t state,
	input logic enter,
	input logic mem_ok,
	input pm_pkg::instr_word_t ir,
	input logic [2:0] lg,
	input logic lg_done,
	input logic lk_zero,
	output logic w_ir,
	output logic w_ar,
	output logic w_r,
	output logic w_ac,
	output logic [2:0] reg_sel,
	output logic step,
	output logic halt,
	output logic exec_done
);

	import pm_pkg::*;

	logic busy;
	logic fetch_ok;
	logic in_exec;
	logic issue_r;
	logic issue_ac;
	logic do_halt;
	logic last_op;
	logic [2:0] sel;

	// fetch answered while P1 still waits for it
	assign fetch_ok = (state == ST_P1) && mem_ok && (busy || enter);
	// P5 work starts once the counters are loaded
	assign in_exec = busy && (state == ST_P5);

	always_comb begin
		issue_r = 1'b0;
		issue_ac = 1'b0;
		do_halt = 1'b0;
		last_op = 1'b0;
		step = 1'b0;
		sel = ir.n.a;
		if (in_exec) begin
			case (ir.n.opcode)
				OP_LW: begin
					issue_r = 1'b1;
					last_op = 1'b1;
				end
				OP_LWS: begin
					issue_r = 1'b1;
					sel = lg;
					step = !lg_done;
					last_op = lg_done;
				end
				OP_SHC: begin
					issue_ac = !lk_zero;
					step = !lk_zero;
					last_op = lk_zero;
				end
				OP_HLT: begin
					do_halt = 1'b1;
					last_op = 1'b1;
				end
				default: last_op = 1'b1;
			endcase
		end
	end

	always_ff @(posedge __clk) begin
		if (reset) begin
			busy <= 1'b0;
			w_ir <= 1'b0;
			w_ar <= 1'b0;
			w_r <= 1'b0;
			w_ac <= 1'b0;
			halt <= 1'b0;
			exec_done <= 1'b0;
		end else begin
			w_ir <= fetch_ok;
			w_ar <= enter && (state == ST_P4);
			w_r <= issue_r;
			w_ac <= issue_ac;
			halt <= do_halt;
			exec_done <= last_op;
			if (enter)
				busy <= (state == ST_P1) || (state == ST_P5);
			else if (fetch_ok || last_op)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge __clk) begin
		if (issue_r)
			reg_sel <= sel;
	end

	a_one_write: assert property (
		@(posedge __clk) disable iff (reset) $onehot0({w_ir, w_r, w_ac})
	) else $error("more than one register write strobe");

endmodule

`default_nettype wire
